//--- timer.f
verilog/timer_cfg_pkg.sv
verilog/timer_reg_pkg.sv
verilog/timer_bus_if.sv
verilog/carry_skip_incrementer.sv
verilog/compare_match_timer.sv
verilog/timer_regs.sv
verilog/tick_prescaler.sv
verilog/timer_top.sv
tests/timer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the timer testbench with Verilator, runs it and judges the result from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/10ps --top-module timer_tb -f timer.f \
    -o timer_sim > "$LOG" 2>&1 \
    && ./obj_dir/timer_sim >> "$LOG" 2>&1 \
    || echo "CHECKS FAILED: build or simulation did not complete" >> "$LOG"

grep -q "CHECKS FAILED" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

//--- tests/timer_tb.sv
// Table-driven testbench for the compare-match timer against a cycle-level reference model
`timescale 1ns/10ps

module timer_tb;

    localparam int COUNT_WIDTH = 24;
    localparam int NUM_FIXED   = 7;
    localparam int NUM_RANDOM  = 4;
    localparam int HOLD_CYCLES = 8;

    typedef struct {
        int prescale;
        int compare;
        int irq_en;
        int run;
    } row_t;

    // Columns are prescale, compare value, irq_enable, run cycles
    int fixed_rows [NUM_FIXED][4] = '{
        '{0, 10, 1, 20},
        '{2, 5, 0, 30},
        '{3, 7, 1, 40},
        '{1, 50, 1, 60},
        '{4, 3, 1, 12},
        '{0, 'h0FF, 1, 270},
        '{0, 'h0FFF, 0, 4110}
    };

    logic                     i_clock = 1'b0;
    logic                     i_nreset;
    logic                     i_wr_valid;
    logic                     o_wr_ready;
    timer_reg_pkg::reg_addr_t i_wr_addr;
    logic [31:0]              i_wr_data;
    logic [COUNT_WIDTH-1:0]   o_counter;
    logic                     o_match;
    logic                     o_irq;

    row_t rows[$];
    int   value_errors    = 0;
    int   other_errors    = 0;
    int   watchdog_cycles = 0;

    // Reference model state for the row in progress
    int   edge_n;
    int   en_limit;
    bit   tracking = 1'b0;
    row_t cur;

    always #50 i_clock = ~i_clock;

    timer_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) timer_top_inst (
        .i_clock    (i_clock),
        .i_nreset   (i_nreset),
        .i_wr_valid (i_wr_valid),
        .o_wr_ready (o_wr_ready),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_counter  (o_counter),
        .o_match    (o_match),
        .o_irq      (o_irq)
    );

    task automatic check_counter(logic [COUNT_WIDTH-1:0] actual,
                                 logic [COUNT_WIDTH-1:0] expected, string what);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_ctrl(timer_cfg_pkg::timer_ctrl_t actual,
                              timer_cfg_pkg::timer_ctrl_t expected, string what);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Raw layout with enable in bit 0, prescale in bits 8:1, irq_enable in bit 9
    function automatic logic [31:0] ctrl_word(logic enable, int prescale, logic irq_enable);
        return (32'(irq_enable) << 9) | ((32'(prescale) & 32'hFF) << 1) | 32'(enable);
    endfunction

    function automatic timer_cfg_pkg::timer_ctrl_t expected_ctrl(logic enable, int prescale,
                                                                 logic irq_enable);
        timer_cfg_pkg::timer_ctrl_t c;
        c            = '0;
        c.enable     = enable;
        c.prescale   = prescale[timer_cfg_pkg::PRESCALE_WIDTH-1:0];
        c.irq_enable = irq_enable;
        return c;
    endfunction

    task automatic next_edge();
        @(posedge i_clock);
        edge_n++;
    endtask

    // Outputs are compared at the falling edge, halfway between drive edges
    task automatic settle_and_check();
        int k;
        int steps;
        bit reached;
        @(negedge i_clock);
        if (tracking) begin
            k       = cur.compare * (cur.prescale + 1);
            steps   = (edge_n < en_limit) ? edge_n : en_limit;
            reached = (cur.compare != 0) && (k <= en_limit);
            check_counter(o_counter, COUNT_WIDTH'(steps / (cur.prescale + 1)), "counter");
            check_flag(o_match, reached && (edge_n == k + 3), "match");
            check_flag(o_irq, reached && (cur.irq_en != 0) && (edge_n >= k + 4), "irq");
        end
    endtask

    task automatic write_reg(timer_reg_pkg::reg_addr_t addr, logic [31:0] data);
        int waits;
        waits = 0;
        next_edge();
        i_wr_valid <= 1'b1;
        i_wr_addr  <= addr;
        i_wr_data  <= data;
        settle_and_check();
        while (!o_wr_ready && waits < 16) begin
            next_edge();
            settle_and_check();
            waits++;
        end
        if (!o_wr_ready) begin
            other_errors++;
            $display("Register write to address %0d was never accepted", addr);
        end
        next_edge();
        i_wr_valid <= 1'b0;
        settle_and_check();
    endtask

    task automatic pulse_reset();
        next_edge();
        i_nreset <= 1'b0;
        repeat (16) next_edge();
        i_nreset <= 1'b1;
        @(negedge i_clock);
        check_flag(o_wr_ready, 1'b0, "ready in reset");
        check_counter(o_counter, '0, "counter after reset");
        check_flag(o_match, 1'b0, "match after reset");
        check_flag(o_irq, 1'b0, "irq after reset");
    endtask

    task automatic run_row(row_t r);
        timer_cfg_pkg::timer_ctrl_t written;
        tracking = 1'b0;
        cur      = r;
        write_reg(timer_reg_pkg::ADDR_CTRL, ctrl_word(1'b0, r.prescale, r.irq_en != 0));
        pulse_reset();
        write_reg(timer_reg_pkg::ADDR_COMPARE, 32'(r.compare));
        write_reg(timer_reg_pkg::ADDR_CTRL, ctrl_word(1'b1, r.prescale, r.irq_en != 0));
        // Control word as latched by the register block
        written = timer_top_inst.ctrl;
        check_ctrl(written, expected_ctrl(1'b1, r.prescale, r.irq_en != 0), "ctrl word");
        // Model time starts at the edge that loaded the enable bit
        edge_n   = 0;
        en_limit = 32'h7fff_ffff;
        tracking = 1'b1;
        repeat (r.run) begin
            next_edge();
            settle_and_check();
        end
        // Two more edges still count before the cleared enable reaches the counter
        en_limit = r.run + 2;
        write_reg(timer_reg_pkg::ADDR_CTRL, ctrl_word(1'b0, r.prescale, r.irq_en != 0));
        repeat (HOLD_CYCLES) begin
            next_edge();
            settle_and_check();
        end
        tracking = 1'b0;
        write_reg(timer_reg_pkg::ADDR_IRQ_CLEAR, 32'd0);
        check_flag(o_irq, 1'b0, "irq after clear");
    endtask

    initial begin
        int   total_run;
        row_t r;
        i_nreset   <= 1'b0;
        i_wr_valid <= 1'b0;
        i_wr_addr  <= '0;
        i_wr_data  <= '0;
        edge_n     = 0;
        en_limit   = 0;
        total_run  = 0;
        void'($urandom(32'h7106));
        for (int i = 0; i < NUM_FIXED; i++) begin
            r = '{fixed_rows[i][0], fixed_rows[i][1], fixed_rows[i][2], fixed_rows[i][3]};
            rows.push_back(r);
        end
        // Random rows always run long enough to reach their compare value
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r.prescale = int'($urandom % 8);
            r.compare  = 1 + int'($urandom % 20);
            r.irq_en   = int'($urandom % 2);
            r.run      = r.compare * (r.prescale + 1) + int'($urandom % 16);
            rows.push_back(r);
        end
        foreach (rows[i]) total_run += rows[i].run;
        watchdog_cycles = total_run + rows.size() * 64 + 256;
        repeat (16) next_edge();
        i_nreset <= 1'b1;
        foreach (rows[i]) run_row(rows[i]);
        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge i_clock);
        other_errors++;
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog/timer_top.sv
// Compare-match timer top level with a plain register write port
`timescale 1ns/10ps

module timer_top #(
    parameter int COUNT_WIDTH = 24
) (
    input  logic                     i_clock,
    input  logic                     i_nreset,
    input  logic                     i_wr_valid,
    output logic                     o_wr_ready,
    input  timer_reg_pkg::reg_addr_t i_wr_addr,
    input  logic [31:0]              i_wr_data,
    output logic [COUNT_WIDTH-1:0]   o_counter,
    output logic                     o_match,
    output logic                     o_irq
);

    timer_cfg_pkg::timer_ctrl_t ctrl;
    logic [COUNT_WIDTH-1:0]     compare;
    logic                       tick;

    timer_bus_if bus_if ();

    assign bus_if.valid = i_wr_valid;
    assign bus_if.addr  = i_wr_addr;
    assign bus_if.wdata = i_wr_data;
    assign o_wr_ready   = bus_if.ready;

    timer_regs #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) timer_regs_inst (
        .i_clock   (i_clock),
        .i_nreset  (i_nreset),
        .bus       (bus_if.target),
        .i_match   (o_match),
        .o_ctrl    (ctrl),
        .o_compare (compare),
        .o_irq     (o_irq)
    );

    tick_prescaler tick_prescaler_inst (
        .i_clock  (i_clock),
        .i_nreset (i_nreset),
        .i_ctrl   (ctrl),
        .o_tick   (tick)
    );

    compare_match_timer #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) compare_match_timer_inst (
        .i_clock   (i_clock),
        .i_nreset  (i_nreset),
        .i_enable  (ctrl.enable),
        .i_tick    (tick),
        .i_compare (compare),
        .o_match   (o_match),
        .o_counter (o_counter)
    );

endmodule

//--- verilog/tick_prescaler.sv
// Tick prescaler that divides the clock by the programmed prescale value plus one
`timescale 1ns/10ps

module tick_prescaler (
    input  logic                       i_clock,
    input  logic                       i_nreset,
    input  timer_cfg_pkg::timer_ctrl_t i_ctrl,
    output logic                       o_tick
);

    logic [timer_cfg_pkg::PRESCALE_WIDTH-1:0] div_count;
    logic [timer_cfg_pkg::PRESCALE_WIDTH-1:0] div_current;
    logic                                      div_running;

    // Until the first reload the divider acts as if loaded with prescale
    assign div_current = div_running ? div_count : i_ctrl.prescale;
    assign o_tick      = i_ctrl.enable && (div_current == '0);

    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            div_count   <= '0;
            div_running <= 1'b0;
        end else if (!i_ctrl.enable) begin
            // Divider restarts from scratch on the next enable
            div_count   <= '0;
            div_running <= 1'b0;
        end else begin
            div_running <= 1'b1;
            if (o_tick) begin
                div_count <= i_ctrl.prescale;
            end else begin
                div_count <= div_current - 1'b1;
            end
        end
    end

endmodule

//--- verilog/timer_regs.sv
// Timer register block for control, compare value and the sticky interrupt flag
`timescale 1ns/10ps

module timer_regs #(
    parameter int COUNT_WIDTH = 24
) (
    input  logic                       i_clock,
    input  logic                       i_nreset,
    timer_bus_if.target                bus,
    input  logic                       i_match,
    output timer_cfg_pkg::timer_ctrl_t o_ctrl,
    output logic [COUNT_WIDTH-1:0]     o_compare,
    output logic                       o_irq
);

    logic ready_q;
    logic wr_fire;
    logic irq_set;
    logic irq_clear;

    // Never back-pressures once out of reset
    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    assign bus.ready = ready_q;
    assign wr_fire   = bus.valid && ready_q;

    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            o_ctrl <= '0;
        end else if (wr_fire && (bus.addr == timer_reg_pkg::ADDR_CTRL)) begin
            o_ctrl <= bus.wdata.ctrl;
        end
    end

    // Compare value comes from the raw view of the same word
    always_ff @(posedge i_clock) begin
        if (wr_fire && (bus.addr == timer_reg_pkg::ADDR_COMPARE)) begin
            o_compare <= bus.wdata.value[COUNT_WIDTH-1:0];
        end
    end

    assign irq_set   = i_match && o_ctrl.irq_enable;
    assign irq_clear = wr_fire && (bus.addr == timer_reg_pkg::ADDR_IRQ_CLEAR);

    // Sticky flag where a set in the same cycle as a clear wins
    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            o_irq <= 1'b0;
        end else if (irq_set) begin
            o_irq <= 1'b1;
        end else if (irq_clear) begin
            o_irq <= 1'b0;
        end
    end

endmodule

//--- verilog/compare_match_timer.sv
// Compare-match timer core with a gated counter and a pipelined equality compare
`timescale 1ns/10ps

module compare_match_timer #(
    parameter int COUNT_WIDTH = 24
) (
    input  logic                   i_clock,
    input  logic                   i_nreset,
    input  logic                   i_enable,
    input  logic                   i_tick,
    input  logic [COUNT_WIDTH-1:0] i_compare,
    output logic                   o_match,
    output logic [COUNT_WIDTH-1:0] o_counter
);

    logic [COUNT_WIDTH-1:0] count_next;
    logic                   count_step;

    // Stage 1 holds the live count
    logic [COUNT_WIDTH-1:0] count_s1;
    logic                   step_s1;

    // Stage 2 lines up count and compare value
    logic [COUNT_WIDTH-1:0] count_s2;
    logic [COUNT_WIDTH-1:0] compare_s2;
    logic                   step_s2;

    logic                   match_s3;

    // Counting is gated by both the enable bit and the prescaler tick
    assign count_step = i_enable && i_tick;

    carry_skip_incrementer #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) incrementer_inst (
        .i_value (count_s1),
        .o_sum   (count_next)
    );

    // step_s1 marks the one cycle in which count_s1 shows a fresh value
    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            count_s1 <= '0;
            step_s1  <= 1'b0;
        end else begin
            step_s1 <= count_step;
            if (count_step) begin
                count_s1 <= count_next;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        count_s2   <= count_s1;
        compare_s2 <= i_compare;
    end

    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            step_s2 <= 1'b0;
        end else begin
            step_s2 <= step_s1;
        end
    end

    // Only a freshly stepped value may match, so a held count gives one pulse
    always_ff @(posedge i_clock) begin
        if (!i_nreset) begin
            match_s3 <= 1'b0;
            o_match  <= 1'b0;
        end else begin
            match_s3 <= step_s2 && (count_s2 == compare_s2);
            o_match  <= match_s3;
        end
    end

    assign o_counter = count_s1;

endmodule

//--- verilog/carry_skip_incrementer.sv
// Carry-skip incrementer built from 4-bit ripple carry blocks
`timescale 1ns/10ps

module carry_skip_incrementer #(
    parameter int COUNT_WIDTH = 24
) (
    input  logic [COUNT_WIDTH-1:0] i_value,
    output logic [COUNT_WIDTH-1:0] o_sum
);

    localparam int NUM_BLOCKS = COUNT_WIDTH / 4;

    // Carry into each 4-bit slice
    logic [NUM_BLOCKS-1:0] carry;

    // The increment enters as the carry into the lowest slice
    assign carry[0] = 1'b1;

    for (genvar k = 0; k < NUM_BLOCKS; k++) begin : g_block
        if (k == NUM_BLOCKS - 1) begin : g_last
            // Carry out of the top slice is the counter wrap and is dropped
            carry_block carry_block_inst (
                .i_a    (i_value[4*k +: 4]),
                .i_cin  (carry[k]),
                .o_sum  (o_sum[4*k +: 4]),
                .o_cout ()
            );
        end else begin : g_inner
            logic block_cout;

            carry_block carry_block_inst (
                .i_a    (i_value[4*k +: 4]),
                .i_cin  (carry[k]),
                .o_sum  (o_sum[4*k +: 4]),
                .o_cout (block_cout)
            );

            if (k == 0) begin : g_first
                assign carry[k+1] = block_cout;
            end else begin : g_skip
                // All ones in the slice lets the incoming carry bypass the ripple
                assign carry[k+1] = (&i_value[4*k +: 4]) ? carry[k] : block_cout;
            end
        end
    end

endmodule

// Four-bit ripple adder with a zero second operand
module carry_block (
    input  logic [3:0] i_a,
    input  logic       i_cin,
    output logic [3:0] o_sum,
    output logic       o_cout
);

    logic [4:0] c;

    assign c[0] = i_cin;

    for (genvar i = 0; i < 4; i++) begin : g_bit
        assign o_sum[i] = i_a[i] ^ c[i];
        assign c[i+1]   = i_a[i] & c[i];
    end

    assign o_cout = c[4];

endmodule

//--- verilog/timer_bus_if.sv
// Timer register write port with valid/ready handshake
`timescale 1ns/10ps

interface timer_bus_if;

    logic                     valid;
    logic                     ready;
    timer_reg_pkg::reg_addr_t addr;
    timer_reg_pkg::reg_word_u wdata;

    // Side that issues register writes
    modport initiator (
        output valid,
        output addr,
        output wdata,
        input  ready
    );

    // Side that accepts register writes
    modport target (
        input  valid,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

//--- verilog/timer_reg_pkg.sv
// Timer register map package with addresses and the decoded write word
package timer_reg_pkg;

    // Register address on the write port
    typedef logic [1:0] reg_addr_t;

    // Register map
    localparam reg_addr_t ADDR_CTRL      = 2'd0;
    localparam reg_addr_t ADDR_COMPARE   = 2'd1;
    localparam reg_addr_t ADDR_IRQ_CLEAR = 2'd2;

    // One write data word, read either as a control word or as a raw value
    // The value view feeds the compare register and only its low bits are kept
    typedef union packed {
        timer_cfg_pkg::timer_ctrl_t ctrl;
        logic [31:0]                value;
    } reg_word_u;

endpackage

//--- verilog/timer_cfg_pkg.sv
// Timer configuration package with the control register layout and prescaler width
package timer_cfg_pkg;

    // Width of the prescale field in the control register
    localparam int PRESCALE_WIDTH = 8;

    // Upper bits of the control word that carry no function
    localparam int CTRL_RSVD_WIDTH = 32 - PRESCALE_WIDTH - 2;

    // Control register as seen by software
    // enable sits in bit 0, prescale in bits 8:1, irq_enable in bit 9
    // A prescale value p gives one count tick every p+1 clocks
    typedef struct packed {
        logic [CTRL_RSVD_WIDTH-1:0] reserved;
        logic                       irq_enable;
        logic [PRESCALE_WIDTH-1:0]  prescale;
        logic                       enable;
    } timer_ctrl_t;

endpackage
